/* common/bridge_pkg.sv */
package bridge_pkg;

    // bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;  // one strobe per byte lane
    localparam int SIZE_W   = 2;           // cpu side size code
    localparam int AXSIZE_W = 3;           // axi side size code
    localparam int ID_W     = 4;           // only ever tied to zero

    // widths of the fixed axi fields
    localparam int LEN_W   = 8;
    localparam int BURST_W = 2;
    localparam int LOCK_W  = 2;
    localparam int CACHE_W = 4;
    localparam int PROT_W  = 3;
    localparam int RESP_W  = 2;

    localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [SIZE_W-1:0]  size_t;

    // cpu size codes
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // one cpu request, as presented with req
    typedef struct packed {
        logic  wr;     // 1 = write
        size_t size;
        addr_t addr;
        word_t wdata;  // don't care on reads
    } sram_req_t;

    // ar / aw payload
    typedef struct packed {
        addr_t               addr;
        logic [AXSIZE_W-1:0] size;
    } axi_addr_t;

    // w payload
    typedef struct packed {
        word_t data;
        strb_t strb;
    } axi_w_t;

    // which cpu port started the transaction in flight
    typedef enum logic {
        OWNER_INST = 1'b0,
        OWNER_DATA = 1'b1
    } owner_t;

endpackage

/* logic/port_arbiter.sv */
`timescale 1ns/1ps

module port_arbiter (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inst_req,
    input  logic                  data_req,
    input  bridge_pkg::sram_req_t inst_cmd,
    input  bridge_pkg::sram_req_t data_cmd,
    output logic                  inst_addr_ok,
    output logic                  data_addr_ok,
    output logic                  inst_data_ok,
    output logic                  data_data_ok,
    output bridge_pkg::word_t     inst_rdata,
    output bridge_pkg::word_t     data_rdata,
    output logic                  rd_start,
    output logic                  wr_start,
    output bridge_pkg::sram_req_t cmd,
    input  logic                  rd_done,
    input  logic                  wr_done,
    input  bridge_pkg::word_t     rd_data
);

    logic               busy;        // one transaction in flight
    bridge_pkg::owner_t owner;       // port that started it
    logic               inst_accept;
    logic               data_accept;
    logic               accept;
    logic               done;

    // data port has priority, inst backs off while data_req is up
    assign data_addr_ok = !busy;
    assign inst_addr_ok = !busy && !data_req;

    assign data_accept = data_req && data_addr_ok;
    assign inst_accept = inst_req && inst_addr_ok;
    assign accept      = data_accept || inst_accept;

    // winning request goes to both controllers
    assign cmd = data_req ? data_cmd : inst_cmd;

    assign rd_start = accept && !cmd.wr;  // split by direction
    assign wr_start = accept && cmd.wr;

    assign done = rd_done || wr_done;  // only one can be active

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            owner <= bridge_pkg::OWNER_INST;
        end
        else if (accept)
        begin
            busy  <= 1'b1;
            owner <= data_accept ? bridge_pkg::OWNER_DATA : bridge_pkg::OWNER_INST;
        end
        else if (done)
        begin
            busy <= 1'b0;  // addr_ok back the cycle after data_ok
        end
    end

    // completion only to the owner
    assign inst_data_ok = busy && done && (owner == bridge_pkg::OWNER_INST);
    assign data_data_ok = busy && done && (owner == bridge_pkg::OWNER_DATA);

    // read data only during a read completion, zero otherwise
    assign inst_rdata = (inst_data_ok && rd_done) ? rd_data : '0;
    assign data_rdata = (data_data_ok && rd_done) ? rd_data : '0;

endmodule

/* axi_read/axi_read_ctrl.sv */
`timescale 1ns/1ps

module axi_read_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  rd_start,
    input  bridge_pkg::sram_req_t cmd,
    output bridge_pkg::axi_addr_t ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  bridge_pkg::word_t     rdata,
    input  logic                  rvalid,
    output logic                  rready,
    output logic                  rd_done,
    output bridge_pkg::word_t     rd_data
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,  // arvalid up, waiting for arready
        RD_DATA   // rready up, waiting for rvalid
    } rd_state_t;

    rd_state_t state;
    logic      ar_hs;
    logic      r_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= RD_IDLE;
        end
        else
        begin
            case (state)
                RD_IDLE:
                    if (rd_start)
                        state <= RD_ADDR;
                RD_ADDR:
                    if (ar_hs)
                        state <= RD_DATA;
                RD_DATA:
                    if (r_hs)
                        state <= RD_IDLE;  // single beat, done
                default:
                    state <= RD_IDLE;
            endcase
        end
    end

    // address payload, held stable until the ar handshake
    always_ff @(posedge clk)
    begin
        if (rd_start)
        begin
            ar.addr <= cmd.addr;
            ar.size <= {1'b0, cmd.size};  // widen to axi size
        end
    end

    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);

    assign rd_done = r_hs;   // same cycle as the r handshake
    assign rd_data = rdata;  // arbiter qualifies with rd_done

endmodule

/* axi_write/axi_write_ctrl.sv */
`timescale 1ns/1ps

module axi_write_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  wr_start,
    input  bridge_pkg::sram_req_t cmd,
    output bridge_pkg::axi_addr_t aw,
    output logic                  awvalid,
    input  logic                  awready,
    output bridge_pkg::axi_w_t    w,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready,
    output logic                  wr_done
);

    logic active;   // write in flight
    logic aw_done;  // aw handshake seen
    logic w_done;   // w handshake seen
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    // byte lanes touched by size at the given offset
    function automatic bridge_pkg::strb_t strb_for(
        input bridge_pkg::size_t size,
        input logic [1:0]        offset
    );
        bridge_pkg::strb_t strb;
        strb = '0;  // misaligned or unknown size writes nothing
        case (size)
            bridge_pkg::SIZE_BYTE:
                strb = bridge_pkg::strb_t'(1) << offset;
            bridge_pkg::SIZE_HALF:
            begin
                if (offset == 2'd0)
                    strb = 4'b0011;
                else if (offset == 2'd2)
                    strb = 4'b1100;
            end
            bridge_pkg::SIZE_WORD:
                if (offset == 2'd0)
                    strb = 4'b1111;
            default:
                strb = '0;
        endcase
        return strb;
    endfunction

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    // aw and w may finish in either order, or together
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            active  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end
        else if (wr_start)
        begin
            active  <= 1'b1;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end
        else if (b_hs)
        begin
            active  <= 1'b0;  // response taken, back to idle
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end
        else
        begin
            if (aw_hs)
                aw_done <= 1'b1;
            if (w_hs)
                w_done <= 1'b1;
        end
    end

    // payloads captured once at accept, stable while valid is held
    always_ff @(posedge clk)
    begin
        if (wr_start)
        begin
            aw.addr <= cmd.addr;
            aw.size <= {1'b0, cmd.size};
            w.data  <= cmd.wdata;
            w.strb  <= strb_for(cmd.size, cmd.addr[1:0]);
        end
    end

    assign awvalid = active && !aw_done;
    assign wvalid  = active && !w_done;
    assign bready  = active && aw_done && w_done;  // after both handshakes

    assign wr_done = b_hs;

endmodule

/* logic/cpu_axi_bridge.sv */
`timescale 1ns/1ps

module cpu_axi_bridge (
    input  logic                                  clk,
    input  logic                                  resetn,

    // instruction port
    input  logic                                  inst_req,
    input  bridge_pkg::sram_req_t                 inst_cmd,
    output logic                                  inst_addr_ok,
    output logic                                  inst_data_ok,
    output bridge_pkg::word_t                     inst_rdata,

    // data port
    input  logic                                  data_req,
    input  bridge_pkg::sram_req_t                 data_cmd,
    output logic                                  data_addr_ok,
    output logic                                  data_data_ok,
    output bridge_pkg::word_t                     data_rdata,

    // ar
    output logic [bridge_pkg::ID_W-1:0]           arid,
    output bridge_pkg::addr_t                     araddr,
    output logic [bridge_pkg::LEN_W-1:0]          arlen,
    output logic [bridge_pkg::AXSIZE_W-1:0]       arsize,
    output logic [bridge_pkg::BURST_W-1:0]        arburst,
    output logic [bridge_pkg::LOCK_W-1:0]         arlock,
    output logic [bridge_pkg::CACHE_W-1:0]        arcache,
    output logic [bridge_pkg::PROT_W-1:0]         arprot,
    output logic                                  arvalid,
    input  logic                                  arready,

    // r
    input  logic [bridge_pkg::ID_W-1:0]           rid,     // single outstanding, not needed
    input  bridge_pkg::word_t                     rdata,
    input  logic [bridge_pkg::RESP_W-1:0]         rresp,   // errors not reported
    input  logic                                  rlast,   // always one beat
    input  logic                                  rvalid,
    output logic                                  rready,

    // aw
    output logic [bridge_pkg::ID_W-1:0]           awid,
    output bridge_pkg::addr_t                     awaddr,
    output logic [bridge_pkg::LEN_W-1:0]          awlen,
    output logic [bridge_pkg::AXSIZE_W-1:0]       awsize,
    output logic [bridge_pkg::BURST_W-1:0]        awburst,
    output logic [bridge_pkg::LOCK_W-1:0]         awlock,
    output logic [bridge_pkg::CACHE_W-1:0]        awcache,
    output logic [bridge_pkg::PROT_W-1:0]         awprot,
    output logic                                  awvalid,
    input  logic                                  awready,

    // w
    output logic [bridge_pkg::ID_W-1:0]           wid,
    output bridge_pkg::word_t                     wdata,
    output bridge_pkg::strb_t                     wstrb,
    output logic                                  wlast,
    output logic                                  wvalid,
    input  logic                                  wready,

    // b
    input  logic [bridge_pkg::ID_W-1:0]           bid,
    input  logic [bridge_pkg::RESP_W-1:0]         bresp,
    input  logic                                  bvalid,
    output logic                                  bready
);

    bridge_pkg::sram_req_t cmd;  // accepted request
    bridge_pkg::axi_addr_t ar;
    bridge_pkg::axi_addr_t aw;
    bridge_pkg::axi_w_t    w;
    bridge_pkg::word_t     rd_data;
    logic                  rd_start;
    logic                  wr_start;
    logic                  rd_done;
    logic                  wr_done;

    port_arbiter i_port_arbiter (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .data_req     (data_req),
        .inst_cmd     (inst_cmd),
        .data_cmd     (data_cmd),
        .inst_addr_ok (inst_addr_ok),
        .data_addr_ok (data_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_data_ok (data_data_ok),
        .inst_rdata   (inst_rdata),
        .data_rdata   (data_rdata),
        .rd_start     (rd_start),
        .wr_start     (wr_start),
        .cmd          (cmd),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .rd_data      (rd_data)
    );

    axi_read_ctrl i_axi_read_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .rd_start (rd_start),
        .cmd      (cmd),
        .ar       (ar),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready),
        .rd_done  (rd_done),
        .rd_data  (rd_data)
    );

    axi_write_ctrl i_axi_write_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .wr_start (wr_start),
        .cmd      (cmd),
        .aw       (aw),
        .awvalid  (awvalid),
        .awready  (awready),
        .w        (w),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .wr_done  (wr_done)
    );

    // payload structs out onto the bus
    assign araddr = ar.addr;
    assign arsize = ar.size;
    assign awaddr = aw.addr;
    assign awsize = aw.size;
    assign wdata  = w.data;
    assign wstrb  = w.strb;

    // fixed fields, single beat incr, normal access, id 0
    assign arid    = '0;
    assign arlen   = '0;
    assign arburst = bridge_pkg::BURST_INCR;
    assign arlock  = '0;
    assign arcache = '0;
    assign arprot  = '0;
    assign awid    = '0;
    assign awlen   = '0;
    assign awburst = bridge_pkg::BURST_INCR;
    assign awlock  = '0;
    assign awcache = '0;
    assign awprot  = '0;
    assign wid     = '0;
    assign wlast   = 1'b1;  // every beat is the last

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial
    begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        resetn = 1'b1;
    end

endmodule

/* verif/tb_cpu_axi_bridge.sv */
`timescale 1ns/1ps

module tb_cpu_axi_bridge;

    localparam int MEM_WORDS = 64;  // bytes 0x00..0xff

    logic clk, resetn;
    logic inst_req, data_req, inst_addr_ok, data_addr_ok, inst_data_ok, data_data_ok;
    bridge_pkg::sram_req_t inst_cmd, data_cmd;
    bridge_pkg::word_t inst_rdata, data_rdata, rdata, wdata;
    bridge_pkg::addr_t araddr, awaddr;
    bridge_pkg::strb_t wstrb;
    logic [bridge_pkg::ID_W-1:0] arid, rid, awid, wid, bid;
    logic [bridge_pkg::LEN_W-1:0] arlen, awlen;
    logic [bridge_pkg::AXSIZE_W-1:0] arsize, awsize;
    logic [bridge_pkg::BURST_W-1:0] arburst, awburst;
    logic [bridge_pkg::LOCK_W-1:0] arlock, awlock;
    logic [bridge_pkg::CACHE_W-1:0] arcache, awcache;
    logic [bridge_pkg::PROT_W-1:0] arprot, awprot;
    logic [bridge_pkg::RESP_W-1:0] rresp, bresp;
    logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic wlast, wvalid, wready, bvalid, bready;

    integer seed;
    string  test_name;
    int     errors, checks, tests, failed_tests, errors_at_start, ar_wait, aw_wait, w_wait;
    int     r_wait, b_wait;
    int     acc_cnt[2];
    int     ok_cnt[2];
    bridge_pkg::word_t  slave_mem[MEM_WORDS];
    bridge_pkg::word_t  ref_mem[MEM_WORDS];
    bridge_pkg::owner_t accept_log[$];
    // slave side state
    logic r_pend, b_pend, s_aw, s_w;
    bridge_pkg::addr_t r_addr, s_addr;
    bridge_pkg::word_t s_data;
    bridge_pkg::strb_t s_strb;
    // what the compare process expects for the transaction in flight
    logic inflight;
    bridge_pkg::owner_t exp_owner;
    bridge_pkg::sram_req_t exp_cmd;
    bridge_pkg::word_t exp_rdata;

    tb_clock_gen i_tb_clock_gen (.clk(clk), .resetn(resetn));

    cpu_axi_bridge i_cpu_axi_bridge (.*);

    // lanes written for a cpu size code at a byte offset
    function automatic bridge_pkg::strb_t ref_strb(input bridge_pkg::size_t size,
                                                   input bridge_pkg::addr_t addr);
        case ({size, addr[1:0]})
            4'b00_00: return 4'b0001;
            4'b00_01: return 4'b0010;
            4'b00_10: return 4'b0100;
            4'b00_11: return 4'b1000;
            4'b01_00: return 4'b0011;
            4'b01_10: return 4'b1100;
            4'b10_00: return 4'b1111;
            default:  return 4'b0000;  // misaligned writes nothing
        endcase
    endfunction

    function automatic bridge_pkg::word_t ref_merge(input bridge_pkg::word_t old,
                                                    input bridge_pkg::word_t data,
                                                    input bridge_pkg::strb_t strb);
        bridge_pkg::word_t res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    // axi size code is log2 of the bytes moved
    function automatic bridge_pkg::axi_addr_t ref_axi_addr(input bridge_pkg::sram_req_t c);
        bridge_pkg::axi_addr_t a;
        a.addr = c.addr;
        case (c.size)
            bridge_pkg::SIZE_BYTE: a.size = 3'd0;  // 1 byte
            bridge_pkg::SIZE_HALF: a.size = 3'd1;  // 2 bytes
            default:               a.size = 3'd2;  // 4 bytes
        endcase
        return a;
    endfunction

    function automatic bridge_pkg::word_t fill_word(input bridge_pkg::addr_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0000;
    endfunction

    function automatic bridge_pkg::sram_req_t make_cmd(input logic              wr,
                                                       input bridge_pkg::size_t size,
                                                       input bridge_pkg::addr_t addr,
                                                       input bridge_pkg::word_t data);
        bridge_pkg::sram_req_t c;
        c.wr    = wr;
        c.size  = size;
        c.addr  = addr;
        c.wdata = data;
        return c;
    endfunction

    function automatic int rand_delay();
        logic [31:0] r;
        r = $random(seed);
        return {30'd0, r[1:0]};  // 0 to 3 cycles
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic compare_word(input string what, input bridge_pkg::word_t exp,
                                input bridge_pkg::word_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_strb(input string what, input bridge_pkg::strb_t exp,
                                input bridge_pkg::strb_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic compare_addr(input string what, input bridge_pkg::axi_addr_t exp,
                                input bridge_pkg::axi_addr_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %s %s: expected %h/%0d actual %h/%0d", test_name, what,
                     exp.addr, exp.size, act.addr, act.size);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR %s: timed out waiting for %s", test_name, msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // slave valid/ready after 0 to 3 cycles, dropped once the work is gone
    task automatic step_delay(input logic pending, inout logic flag, inout int cnt);
        if (!pending)
        begin
            flag = 1'b0;
            cnt  = rand_delay();
        end
        else if (!flag)
        begin
            if (cnt == 0)
                flag = 1'b1;
            else
                cnt--;
        end
    endtask

    always @(negedge clk)
    begin
        if (!resetn)
        begin
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            bvalid  = 1'b0;
        end
        else
        begin
            step_delay(arvalid, arready, ar_wait);
            step_delay(awvalid, awready, aw_wait);
            step_delay(wvalid, wready, w_wait);
            step_delay(r_pend, rvalid, r_wait);
            step_delay(b_pend, bvalid, b_wait);
        end
        rdata = rvalid ? slave_mem[r_addr[7:2]] : 32'hdead_beef;  // junk outside a beat
    end

    task automatic note_accept(input bridge_pkg::owner_t port, input bridge_pkg::sram_req_t c);
        if (inflight)
            report("request accepted while another one is in flight");
        inflight  = 1'b1;
        exp_owner = port;
        exp_cmd   = c;
        acc_cnt[port]++;
        accept_log.push_back(port);
        if (c.wr)
            ref_mem[c.addr[7:2]] = ref_merge(ref_mem[c.addr[7:2]], c.wdata,
                                             ref_strb(c.size, c.addr));
        else
            exp_rdata = ref_mem[c.addr[7:2]];
    endtask

    task automatic note_done(input bridge_pkg::owner_t port, input bridge_pkg::word_t rd);
        if (!inflight)
            report("data_ok with no request in flight");
        else if (port != exp_owner)
            report("data_ok on the port that did not make the request");
        else if (!exp_cmd.wr)
            compare_word("read data", exp_rdata, rd);
        else
            compare_word("rdata on write", '0, rd);
        ok_cnt[port]++;
        inflight = 1'b0;
    endtask

    // compare process, all values taken at the rising edge
    always @(posedge clk)
    begin
        if (resetn)
        begin
            if (inst_data_ok && data_data_ok)
                report("data_ok high on both ports in one cycle");
            if (inst_data_ok)
                note_done(bridge_pkg::OWNER_INST, inst_rdata);
            else
                compare_word("inst_rdata idle", '0, inst_rdata);
            if (data_data_ok)
                note_done(bridge_pkg::OWNER_DATA, data_rdata);
            else
                compare_word("data_rdata idle", '0, data_rdata);
            if (data_req)
                compare_flag("inst_addr_ok with data_req", 1'b0, inst_addr_ok);
            if (arvalid && arready)
            begin
                compare_addr("ar payload", ref_axi_addr(exp_cmd), {araddr, arsize});
                compare_flag("arlen zero", 1'b1, arlen == '0);
                compare_flag("arburst incr", 1'b1, arburst == bridge_pkg::BURST_INCR);
                compare_flag("ar id lock cache prot zero", 1'b1,
                             {arid, arlock, arcache, arprot} == '0);
                r_pend = 1'b1;
                r_addr = araddr;
            end
            if (rvalid && rready)
                r_pend = 1'b0;
            if (awvalid && awready)
            begin
                compare_addr("aw payload", ref_axi_addr(exp_cmd), {awaddr, awsize});
                compare_flag("awlen zero", 1'b1, awlen == '0);
                compare_flag("awburst incr", 1'b1, awburst == bridge_pkg::BURST_INCR);
                compare_flag("aw id lock cache prot zero", 1'b1,
                             {awid, awlock, awcache, awprot} == '0);
                s_aw   = 1'b1;
                s_addr = awaddr;
            end
            if (wvalid && wready)
            begin
                compare_word("wdata", exp_cmd.wdata, wdata);
                compare_strb("wstrb", ref_strb(exp_cmd.size, exp_cmd.addr), wstrb);
                compare_flag("wid zero", 1'b1, wid == '0);
                compare_flag("wlast", 1'b1, wlast);
                s_w    = 1'b1;
                s_data = wdata;
                s_strb = wstrb;
            end
            if (s_aw && s_w)  // both channels in, commit and answer on b
            begin
                slave_mem[s_addr[7:2]] = ref_merge(slave_mem[s_addr[7:2]], s_data, s_strb);
                s_aw   = 1'b0;
                s_w    = 1'b0;
                b_pend = 1'b1;
            end
            if (bvalid && bready)
                b_pend = 1'b0;
            if (data_req && data_addr_ok)
                note_accept(bridge_pkg::OWNER_DATA, data_cmd);
            else if (inst_req && inst_addr_ok)
                note_accept(bridge_pkg::OWNER_INST, inst_cmd);
        end
    end

    // one request on one port, held until accepted, then wait for data_ok
    task automatic run_request(input bridge_pkg::owner_t port, input bridge_pkg::sram_req_t c);
        int   cycles;
        logic hit;
        @(negedge clk);
        if (port == bridge_pkg::OWNER_DATA)
        begin
            data_req = 1'b1;
            data_cmd = c;
        end
        else
        begin
            inst_req = 1'b1;
            inst_cmd = c;
        end
        cycles = 0;
        hit    = 1'b0;
        while (!hit)
        begin
            @(posedge clk);
            hit = (port == bridge_pkg::OWNER_DATA) ? data_addr_ok : inst_addr_ok;
            cycles++;
            if (!hit && cycles > 2000)
                abort_run("addr_ok");
        end
        @(negedge clk);
        if (port == bridge_pkg::OWNER_DATA)
            data_req = 1'b0;
        else
            inst_req = 1'b0;
        cycles = 0;
        hit    = 1'b0;
        while (!hit)
        begin
            @(posedge clk);
            hit = (port == bridge_pkg::OWNER_DATA) ? data_data_ok : inst_data_ok;
            cycles++;
            if (!hit && cycles > 100)
                abort_run("data_ok");
        end
    endtask

    task automatic random_port(input bridge_pkg::owner_t port, input int n);
        bridge_pkg::sram_req_t c;
        logic [31:0] r;
        logic [1:0]  off;
        for (int i = 0; i < n; i++)
        begin
            r      = $random(seed);
            c.wr   = r[0];
            c.size = (r[2:1] == 2'd3) ? bridge_pkg::SIZE_WORD : r[2:1];
            off    = r[4:3];
            if (c.size == bridge_pkg::SIZE_HALF)
                off[0] = 1'b0;
            else if (c.size == bridge_pkg::SIZE_WORD)
                off = 2'd0;
            c.addr  = {24'd0, r[10:5], off};
            c.wdata = $random(seed);
            repeat (r[12:11]) @(negedge clk);  // idle gap lets the other port in
            run_request(port, c);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        @(negedge clk);  // last data_ok has been logged by now
        if (inflight)
            report("transaction still in flight at the end of the test");
        if (errors == errors_at_start)
            $display("test %s: ok", test_name);
        else
        begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial
    begin
        int cycles;
        inst_req = 1'b0;
        data_req = 1'b0;
        inst_cmd = '0;
        data_cmd = '0;
        {arready, awready, wready, rvalid, bvalid, rlast} = 6'b000001;
        {rid, bid, rresp, bresp} = '0;
        rdata    = '0;
        seed     = 32'he0b2c654;
        {r_pend, b_pend, s_aw, s_w, inflight} = '0;
        {errors, checks, tests, failed_tests} = '0;
        acc_cnt  = '{0, 0};
        ok_cnt   = '{0, 0};
        test_name = "reset";
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            slave_mem[i] = fill_word(i * 4);
            ref_mem[i]   = fill_word(i * 4);
        end
        cycles = 0;
        while (resetn !== 1'b1)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 50)
                abort_run("reset release");
        end

        start_test("reset_state");
        repeat (3)
        begin
            @(negedge clk);
            compare_flag("arvalid", 1'b0, arvalid);
            compare_flag("awvalid", 1'b0, awvalid);
            compare_flag("wvalid", 1'b0, wvalid);
            compare_flag("rready", 1'b0, rready);
            compare_flag("bready", 1'b0, bready);
            compare_flag("inst_data_ok", 1'b0, inst_data_ok);
            compare_flag("data_data_ok", 1'b0, data_data_ok);
            compare_flag("inst_addr_ok", 1'b1, inst_addr_ok);
            compare_flag("data_addr_ok", 1'b1, data_addr_ok);
        end
        end_test();

        start_test("word_write_read");
        run_request(bridge_pkg::OWNER_DATA,
                    make_cmd(1'b1, bridge_pkg::SIZE_WORD, 32'h10, 32'hcafe_f00d));
        run_request(bridge_pkg::OWNER_DATA, make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h10, '0));
        end_test();

        start_test("byte_half_strobes");
        for (int off = 0; off < 4; off++)
            run_request(bridge_pkg::OWNER_DATA, make_cmd(1'b1, bridge_pkg::SIZE_BYTE,
                        32'h20 + off, 32'h1122_3344 ^ {4{8'(off)}}));
        run_request(bridge_pkg::OWNER_DATA,
                    make_cmd(1'b1, bridge_pkg::SIZE_HALF, 32'h24, 32'h0000_beef));
        run_request(bridge_pkg::OWNER_DATA,
                    make_cmd(1'b1, bridge_pkg::SIZE_HALF, 32'h26, 32'hd00d_0000));
        run_request(bridge_pkg::OWNER_DATA, make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h20, '0));
        run_request(bridge_pkg::OWNER_DATA, make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h24, '0));
        end_test();

        start_test("port_priority");
        run_request(bridge_pkg::OWNER_INST, make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h10, '0));
        accept_log.delete();
        fork
            run_request(bridge_pkg::OWNER_DATA,
                        make_cmd(1'b1, bridge_pkg::SIZE_WORD, 32'h30, 32'h600d_cafe));
            run_request(bridge_pkg::OWNER_INST,
                        make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h30, '0));
        join
        if (accept_log.size() != 2)
            report("expected two accepts for the simultaneous requests");
        else if (accept_log[0] != bridge_pkg::OWNER_DATA || accept_log[1] != bridge_pkg::OWNER_INST)
            report("simultaneous requests not accepted data first, then instruction");
        end_test();

        start_test("axi_fields");  // payloads are checked at every handshake
        run_request(bridge_pkg::OWNER_DATA,
                    make_cmd(1'b1, bridge_pkg::SIZE_HALF, 32'h42, 32'h7788_0000));
        run_request(bridge_pkg::OWNER_INST, make_cmd(1'b0, bridge_pkg::SIZE_BYTE, 32'h43, '0));
        run_request(bridge_pkg::OWNER_DATA,
                    make_cmd(1'b1, bridge_pkg::SIZE_BYTE, 32'h41, 32'h0000_5500));
        run_request(bridge_pkg::OWNER_DATA, make_cmd(1'b0, bridge_pkg::SIZE_WORD, 32'h40, '0));
        end_test();

        start_test("random_mix");
        fork
            random_port(bridge_pkg::OWNER_DATA, 100);
            random_port(bridge_pkg::OWNER_INST, 100);
        join
        @(negedge clk);  // let the last data_ok be counted
        if (acc_cnt[bridge_pkg::OWNER_INST] != ok_cnt[bridge_pkg::OWNER_INST])
            report("instruction port accepts and data_ok pulses differ");
        if (acc_cnt[bridge_pkg::OWNER_DATA] != ok_cnt[bridge_pkg::OWNER_DATA])
            report("data port accepts and data_ok pulses differ");
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verilog.f */
common/bridge_pkg.sv
logic/port_arbiter.sv
axi_read/axi_read_ctrl.sv
axi_write/axi_write_ctrl.sv
logic/cpu_axi_bridge.sv
verif/tb_clock_gen.sv
verif/tb_cpu_axi_bridge.sv

/* Makefile */
TOP = tb_cpu_axi_bridge
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
